/* filelist.f */
cpl_pkg.sv
cpl_split_fsm.sv
cpl_data_credit.sv
cpl_header_builder.sv
tlp_txresp_cntrl.sv
tb_tlp_txresp_cntrl.sv

/* Makefile */
SIM      := verilator
TOP      := tb_tlp_txresp_cntrl
FILELIST := filelist.f
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)

/* tb_tlp_txresp_cntrl.sv */
`timescale 1ns/10ps

module tb_tlp_txresp_cntrl;

  localparam int NUM_REQ    = 40;
  localparam int CLK_PERIOD = 20;

  logic        avl_clk = 1'b0;
  logic        rstn;
  logic        pndg_empty;
  logic [56:0] pndg_dato;
  logic        pndg_rd_req;
  logic        rd_data_valid;
  logic [98:0] cmd_datin;
  logic        cmd_wr_req;
  logic [3:0]  cmd_usedw;
  logic [8:0]  ram_wr_addr;
  logic        cmd_busy;
  logic [31:0] dev_csr;
  logic [12:0] bus_dev;
  logic        resp_idle;

  integer      seed;
  int          err_cnt;
  int          chk_cnt;
  int          beat_cnt;
  int          pend_beats;
  int          consumed;
  int          done_cnt;
  int          req_done;
  int          cyc_cnt;
  logic        active;
  logic        released;
  logic        all_done;
  logic [56:0] cur_req;
  logic [2:0]  cur_mps;
  logic [56:0] req_q[$];
  logic [2:0]  mps_q[$];
  int          exp_size[$];
  logic [11:0] exp_rem[$];
  logic [6:0]  exp_laddr[$];
  logic        exp_last[$];

  tlp_txresp_cntrl DUT (
    .AvlClk_i            (avl_clk),
    .Rstn_i              (rstn),
    .RxPndgRdFifoEmpty_i (pndg_empty),
    .RxPndgRdFifoDato_i  (pndg_dato),
    .RxPndgRdFifoRdReq_o (pndg_rd_req),
    .TxReadDataValid_i   (rd_data_valid),
    .CmdFifoDatin_o      (cmd_datin),
    .CmdFifoWrReq_o      (cmd_wr_req),
    .CmdFifoUsedw_i      (cmd_usedw),
    .CplRamWrAddr_o      (ram_wr_addr),
    .CmdFifoBusy_i       (cmd_busy),
    .DevCsr_i            (dev_csr),
    .BusDev_i            (bus_dev),
    .TxRespIdle_o        (resp_idle)
  );

  initial
  begin
    forever #(CLK_PERIOD / 2) avl_clk = ~avl_clk;
  end

  // extra bytes returned ahead of or behind the read for 64-bit alignment
  function automatic int over_read_bytes(input logic [4:0] dwaddr, input logic [10:0] dwlen);
    int bytes;
    case (dwlen[1:0])
      2'd1: bytes = 12;
      2'd2: bytes = (dwaddr[1:0] == 2'd3) ? 24 : 8;
      2'd3: bytes = (dwaddr[1:0] >= 2'd2) ? 20 : 4;
      default: bytes = ((dwaddr[1:0] != 2'd0) && (dwlen >= 11'd4)) ? 16 : 0;
    endcase
    return bytes;
  endfunction

  // disabled bytes of a contiguous first byte enable
  function automatic int first_mask(input logic [3:0] fbe);
    return 4 - int'($countones(fbe));
  endfunction

  function automatic int last_mask(input logic [3:0] lbe);
    int bytes;
    case (lbe)
      4'b0111: bytes = 1;
      4'b0011: bytes = 2;
      4'b0001: bytes = 3;
      default: bytes = 0;
    endcase
    return bytes;
  endfunction

  function automatic logic [1:0] first_offset(input logic [3:0] fbe);
    logic [1:0] ofs;
    ofs = 2'd0;
    for (int i = 3; i >= 0; i--)
    begin
      if (fbe[i])
        ofs = 2'(i);
    end
    return ofs;
  endfunction

  function automatic logic [98:0] expected_cmd(input logic [56:0] req, input int size,
                                               input logic [11:0] rem, input logic [6:0] laddr);
    logic [98:0] w;
    w        = '0;
    w[6:0]   = laddr;
    w[14:7]  = req[7:0];
    w[30:15] = req[31:16];
    w[68]    = 1'b1;
    w[81:70] = rem;
    w[84:82] = req[51:49];
    w[93:85] = 9'(size / 4);
    w[95:94] = req[48:47];
    return w;
  endfunction

  task automatic build_requests();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [56:0] req;
    logic [3:0]  fbe;
    logic [3:0]  lbe;
    int          s;
    int          k;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      r1  = $random(seed);
      r2  = $random(seed);
      s   = int'(r1[1:0]);
      k   = int'(r1[4:2]) % (4 - s) + 1;
      fbe = 4'(((1 << k) - 1) << s);
      case (r1[6:5])
        2'd0: lbe = 4'b1111;
        2'd1: lbe = 4'b0111;
        2'd2: lbe = 4'b0011;
        default: lbe = 4'b0001;
      endcase
      req         = '0;
      req[7:0]    = r2[7:0];
      req[14:10]  = r2[12:8];
      req[31:16]  = r2[31:16];
      req[42:32]  = 11'(r1[13:7]) + 11'd1;
      req[46:43]  = fbe;
      req[48:47]  = r1[15:14];
      req[51:49]  = r1[18:16];
      req[55:52]  = lbe;
      req_q.push_back(req);
      mps_q.push_back(r1[19] ? 3'd0 : r1[22:20]);
    end
  endtask

  // completion model, a first one up to the 128 byte boundary, then max payload pieces
  task automatic queue_completions(input logic [56:0] req, input logic [2:0] mps_code);
    int   cnt;
    int   rcb;
    int   mps;
    int   size;
    int   fm;
    logic first;
    logic last;
    cnt   = int'(req[42:32]) * 4;
    rcb   = 128 - int'(req[14:10]) * 4;
    mps   = (mps_code == 3'd0) ? 128 : 256;
    first = 1'b1;
    last  = 1'b0;
    while (!last)
    begin
      last = first ? (cnt <= rcb) : (cnt <= mps);
      if (last)
        size = cnt;
      else
        size = first ? rcb : mps;
      fm = first ? first_mask(req[46:43]) : 0;
      exp_size.push_back(size);
      exp_rem.push_back(12'(cnt - fm - last_mask(req[55:52])));
      exp_laddr.push_back(first ? {req[14:10], first_offset(req[46:43])} : 7'd0);
      exp_last.push_back(last);
      cnt   = cnt - size;
      first = 1'b0;
    end
  endtask

  task automatic check_outputs();
    int          size;
    logic [98:0] exp_w;
    if (done_cnt > 0)
    begin
      done_cnt = done_cnt - 1;
      if (done_cnt == 0)
        active = 1'b0;
    end
    if (pndg_rd_req)
    begin
      chk_cnt++;
      if (pndg_empty || active || (req_q.size() == 0))
      begin
        $display("Error at %0t: read pulse with empty FIFO or read in progress", $time);
        err_cnt++;
      end
      else
      begin
        cur_req = req_q.pop_front();
        cur_mps = mps_q.pop_front();
        queue_completions(cur_req, cur_mps);
        consumed   = consumed + over_read_bytes(cur_req[14:10], cur_req[42:32]);
        pend_beats = pend_beats + (int'(cur_req[42:32]) * 4
                     + over_read_bytes(cur_req[14:10], cur_req[42:32])) / 16;
        active     = 1'b1;
      end
    end
    chk_cnt++;
    if (resp_idle !== (pndg_empty && !active))
    begin
      $display("Error at %0t: idle is %b, expected %b", $time, resp_idle, pndg_empty && !active);
      err_cnt++;
    end
    chk_cnt++;
    if (ram_wr_addr !== 9'(beat_cnt))
    begin
      $display("Error at %0t: buffer address %0d, expected %0d", $time, ram_wr_addr,
               beat_cnt % 512);
      err_cnt++;
    end
    if (cmd_wr_req)
    begin
      chk_cnt++;
      if (!active || (exp_size.size() == 0))
      begin
        $display("Error at %0t: write pulse with no completion expected", $time);
        err_cnt++;
      end
      else
      begin
        // inputs still hold the values of the cycle that enabled the write
        if (cmd_busy || (cmd_usedw >= 4'd8))
        begin
          $display("Error at %0t: write under back-pressure, busy %b used %0d", $time,
                   cmd_busy, cmd_usedw);
          err_cnt++;
        end
        size = exp_size.pop_front();
        if (beat_cnt * 16 < consumed + size)
        begin
          $display("Error at %0t: %0d bytes returned, %0d needed", $time, beat_cnt * 16,
                   consumed + size);
          err_cnt++;
        end
        consumed = consumed + size;
        exp_w    = expected_cmd(cur_req, size, exp_rem.pop_front(), exp_laddr.pop_front());
        if (cmd_datin !== exp_w)
        begin
          $display("Error at %0t: command %h, expected %h", $time, cmd_datin, exp_w);
          err_cnt++;
        end
        if (exp_last.pop_front())
        begin
          done_cnt = 2;
          req_done++;
        end
      end
    end
    if (released && (req_done == NUM_REQ) && !active)
      all_done = 1'b1;
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r             = $random(seed);
    cmd_busy      = (r[2:0] == 3'd0);
    cmd_usedw     = r[7] ? r[6:3] : {1'b0, r[5:3]};
    rd_data_valid = 1'b0;
    // beats come back with random gaps
    if ((pend_beats > 0) && (r[9:8] != 2'd0))
    begin
      rd_data_valid = 1'b1;
      pend_beats--;
      beat_cnt++;
    end
    cyc_cnt++;
    if (cyc_cnt >= 10)
      released = 1'b1;
    pndg_empty = !released || (req_q.size() == 0);
    pndg_dato  = cur_req;
    dev_csr    = {24'h0, cur_mps, 5'h0};
  endtask

  always @(negedge avl_clk)
  begin
    check_outputs();
    drive_inputs();
  end

  initial
  begin
    seed          = 32'hd871a960;
    err_cnt       = 0;
    chk_cnt       = 0;
    beat_cnt      = 0;
    pend_beats    = 0;
    consumed      = 0;
    done_cnt      = 0;
    req_done      = 0;
    cyc_cnt       = 0;
    active        = 1'b0;
    released      = 1'b0;
    all_done      = 1'b0;
    cur_req       = '0;
    cur_mps       = 3'd0;
    pndg_empty    = 1'b1;
    pndg_dato     = '0;
    rd_data_valid = 1'b0;
    cmd_usedw     = 4'd0;
    cmd_busy      = 1'b0;
    dev_csr       = 32'h0;
    bus_dev       = 13'h0;
    rstn          = 1'b0;
    build_requests();
    repeat (4) @(negedge avl_clk);
    rstn = 1'b1;
    wait (all_done);
    repeat (4) @(negedge avl_clk);
    if ((exp_size.size() != 0) || (pend_beats != 0))
    begin
      $display("Error at %0t: %0d completions and %0d beats left over", $time,
               exp_size.size(), pend_beats);
      err_cnt++;
    end
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // about 400 cycles per request is far more than any read needs
  initial
  begin
    #(NUM_REQ * 400 * CLK_PERIOD);
    $display("Timeout: the requests were not all completed after %0d cycles", NUM_REQ * 400);
    $display("Test failed");
    $finish;
  end

endmodule

/* tlp_txresp_cntrl.sv */
`timescale 1ns/10ps

module tlp_txresp_cntrl (
  input  logic                            AvlClk_i,
  input  logic                            Rstn_i,
  // pending read FIFO
  input  logic                            RxPndgRdFifoEmpty_i,
  input  logic [cpl_pkg::REQ_W-1:0]       RxPndgRdFifoDato_i,
  output logic                            RxPndgRdFifoRdReq_o,
  // read data returning from Avalon
  input  logic                            TxReadDataValid_i,
  // command FIFO
  output logic [cpl_pkg::CMD_W-1:0]       CmdFifoDatin_o,
  output logic                            CmdFifoWrReq_o,
  input  logic [3:0]                      CmdFifoUsedw_i,
  output logic [cpl_pkg::BUFF_ADDR_W-1:0] CplRamWrAddr_o,
  input  logic                            CmdFifoBusy_i,
  // configuration
  input  logic [31:0]                     DevCsr_i,
  input  logic [12:0]                     BusDev_i,
  output logic                            TxRespIdle_o
);

  logic [4:0]         req_dwaddr;
  logic [10:0]        req_dwlen;
  logic               ld_bcnt;
  logic               send;
  logic               first_cpl;
  logic               payload_ok;
  logic               idle;
  cpl_pkg::cpl_kind_t cpl_kind;
  cpl_pkg::bcnt_t     bytes_sent;
  cpl_pkg::bcnt_t     curr_bcnt;

  assign req_dwaddr = RxPndgRdFifoDato_i[cpl_pkg::DWADDR_HI:cpl_pkg::DWADDR_LO];
  assign req_dwlen  = RxPndgRdFifoDato_i[cpl_pkg::DWLEN_HI:cpl_pkg::DWLEN_LO];

  cpl_split_fsm u_split_fsm (
    .AvlClk_i            (AvlClk_i),
    .Rstn_i              (Rstn_i),
    .RxPndgRdFifoEmpty_i (RxPndgRdFifoEmpty_i),
    .CmdFifoBusy_i       (CmdFifoBusy_i),
    .CmdFifoUsedw_i      (CmdFifoUsedw_i),
    .max_payload_code_i  (DevCsr_i[cpl_pkg::MPS_CODE_HI:cpl_pkg::MPS_CODE_LO]),
    .req_dwaddr_i        (req_dwaddr),
    .req_dwlen_i         (req_dwlen),
    .payload_ok_i        (payload_ok),
    .RxPndgRdFifoRdReq_o (RxPndgRdFifoRdReq_o),
    .ld_bcnt_o           (ld_bcnt),
    .send_o              (send),
    .first_cpl_o         (first_cpl),
    .cpl_kind_o          (cpl_kind),
    .bytes_sent_o        (bytes_sent),
    .curr_bcnt_o         (curr_bcnt),
    .idle_o              (idle)
  );

  cpl_data_credit u_data_credit (
    .AvlClk_i          (AvlClk_i),
    .Rstn_i            (Rstn_i),
    .TxReadDataValid_i (TxReadDataValid_i),
    .ld_bcnt_i         (ld_bcnt),
    .send_i            (send),
    .cpl_kind_i        (cpl_kind),
    .bytes_sent_i      (bytes_sent),
    .req_dwaddr_i      (req_dwaddr),
    .req_dwlen_i       (req_dwlen),
    .payload_ok_o      (payload_ok),
    .CplRamWrAddr_o    (CplRamWrAddr_o)
  );

  cpl_header_builder u_header_builder (
    .AvlClk_i           (AvlClk_i),
    .Rstn_i             (Rstn_i),
    .RxPndgRdFifoDato_i (RxPndgRdFifoDato_i),
    .ld_bcnt_i          (ld_bcnt),
    .send_i             (send),
    .first_cpl_i        (first_cpl),
    .cpl_kind_i         (cpl_kind),
    .bytes_sent_i       (bytes_sent),
    .curr_bcnt_i        (curr_bcnt),
    .CmdFifoDatin_o     (CmdFifoDatin_o),
    .CmdFifoWrReq_o     (CmdFifoWrReq_o)
  );

  // idle only with nothing in progress and nothing pending
  assign TxRespIdle_o = idle && RxPndgRdFifoEmpty_i;

endmodule

/* cpl_header_builder.sv */
`timescale 1ns/10ps

module cpl_header_builder (
  input  logic                      AvlClk_i,
  input  logic                      Rstn_i,
  input  logic [cpl_pkg::REQ_W-1:0] RxPndgRdFifoDato_i,
  input  logic                      ld_bcnt_i,
  input  logic                      send_i,
  input  logic                      first_cpl_i,
  input  cpl_pkg::cpl_kind_t        cpl_kind_i,
  input  cpl_pkg::bcnt_t            bytes_sent_i,
  input  cpl_pkg::bcnt_t            curr_bcnt_i,
  output logic [cpl_pkg::CMD_W-1:0] CmdFifoDatin_o,
  output logic                      CmdFifoWrReq_o
);

  logic [7:0]                tag;
  logic [15:0]               rid;
  logic [2:0]                tc;
  logic [1:0]                attr;
  logic [3:0]                fbe;
  logic [3:0]                lbe;
  logic [4:0]                dwaddr;
  logic [1:0]                byte_ofs;
  logic [8:0]                dw_len;
  cpl_pkg::bcnt_t            first_mask;
  cpl_pkg::bcnt_t            last_mask;
  cpl_pkg::bcnt_t            remain_next;
  logic [cpl_pkg::REM_W-1:0] remain_q;
  logic [6:0]                laddr_q;

  assign tag    = RxPndgRdFifoDato_i[cpl_pkg::TAG_HI:cpl_pkg::TAG_LO];
  assign rid    = RxPndgRdFifoDato_i[cpl_pkg::RID_HI:cpl_pkg::RID_LO];
  assign tc     = RxPndgRdFifoDato_i[cpl_pkg::TC_HI:cpl_pkg::TC_LO];
  assign attr   = RxPndgRdFifoDato_i[cpl_pkg::ATTR_HI:cpl_pkg::ATTR_LO];
  assign fbe    = RxPndgRdFifoDato_i[cpl_pkg::FBE_HI:cpl_pkg::FBE_LO];
  assign lbe    = RxPndgRdFifoDato_i[cpl_pkg::LBE_HI:cpl_pkg::LBE_LO];
  assign dwaddr = RxPndgRdFifoDato_i[cpl_pkg::DWADDR_HI:cpl_pkg::DWADDR_LO];

  // disabled bytes of the first DW, counted only on the first completion
  always_comb
  begin
    first_mask = '0;
    if (first_cpl_i)
    begin
      case (fbe)
        4'b0001, 4'b0010, 4'b0100, 4'b1000: first_mask = cpl_pkg::bcnt_t'(3);
        4'b0011, 4'b0110, 4'b1100:          first_mask = cpl_pkg::bcnt_t'(2);
        4'b0111, 4'b1110:                   first_mask = cpl_pkg::bcnt_t'(1);
        default:                            first_mask = '0;
      endcase
    end
  end

  always_comb
  begin
    case (lbe)
      4'b0111: last_mask = cpl_pkg::bcnt_t'(1);
      4'b0011: last_mask = cpl_pkg::bcnt_t'(2);
      4'b0001: last_mask = cpl_pkg::bcnt_t'(3);
      default: last_mask = '0;
    endcase
  end

  assign remain_next = curr_bcnt_i - first_mask - last_mask;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      remain_q <= '0;
    else
      remain_q <= remain_next[cpl_pkg::REM_W-1:0];
  end

  // offset of the lowest enabled byte in the first DW
  always_comb
  begin
    casez (fbe)
      4'b???1: byte_ofs = 2'd0;
      4'b??10: byte_ofs = 2'd1;
      4'b?100: byte_ofs = 2'd2;
      4'b1000: byte_ofs = 2'd3;
      default: byte_ofs = 2'd0;
    endcase
  end

  // later completions start on the boundary, so the lower address drops to 0
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      laddr_q <= '0;
    else if (send_i && (cpl_kind_i == cpl_pkg::FIRST))
      laddr_q <= '0;
    else if (ld_bcnt_i)
      laddr_q <= {dwaddr, byte_ofs};
  end

  assign dw_len = bytes_sent_i[10:2];

  always_comb
  begin
    CmdFifoDatin_o = '0;
    CmdFifoDatin_o[cpl_pkg::CMD_LADDR_LO +: 7]          = laddr_q;
    CmdFifoDatin_o[cpl_pkg::CMD_TAG_LO +: 8]            = tag;
    CmdFifoDatin_o[cpl_pkg::CMD_RID_LO +: 16]           = rid;
    CmdFifoDatin_o[cpl_pkg::CMD_UNS_BIT]                = 1'b0;
    CmdFifoDatin_o[cpl_pkg::CMD_ONE_BIT]                = 1'b1;
    CmdFifoDatin_o[cpl_pkg::CMD_FLUSH_BIT]              = 1'b0;
    CmdFifoDatin_o[cpl_pkg::CMD_REM_LO +: cpl_pkg::REM_W] = remain_q;
    CmdFifoDatin_o[cpl_pkg::CMD_TC_LO +: 3]             = tc;
    CmdFifoDatin_o[cpl_pkg::CMD_DWLEN_LO +: 9]          = dw_len;
    CmdFifoDatin_o[cpl_pkg::CMD_ATTR_LO +: 2]           = attr;
  end

  assign CmdFifoWrReq_o = send_i;

endmodule

/* cpl_data_credit.sv */
`timescale 1ns/10ps

module cpl_data_credit (
  input  logic                            AvlClk_i,
  input  logic                            Rstn_i,
  input  logic                            TxReadDataValid_i,
  input  logic                            ld_bcnt_i,
  input  logic                            send_i,
  input  cpl_pkg::cpl_kind_t              cpl_kind_i,
  input  cpl_pkg::bcnt_t                  bytes_sent_i,
  input  logic [4:0]                      req_dwaddr_i,
  input  logic [10:0]                     req_dwlen_i,
  output logic                            payload_ok_o,
  output logic [cpl_pkg::BUFF_ADDR_W-1:0] CplRamWrAddr_o
);

  cpl_pkg::crd_t                   limit_q;
  cpl_pkg::crd_t                   consumed_q;
  cpl_pkg::crd_t                   required_q;
  cpl_pkg::crd_t                   over_rd_bytes;
  cpl_pkg::crd_t                   avail;
  cpl_pkg::cpl_kind_t              kind_q;
  logic                            wait_cyc;
  logic                            pipe_cyc;
  logic                            dwlen_gte_4;
  logic                            payload_ok_q;
  logic [cpl_pkg::BUFF_ADDR_W-1:0] buff_addr_q;

  // the kind leaves NONE for exactly one wait cycle before each pipe stage
  assign wait_cyc = (cpl_kind_i != cpl_pkg::NONE) && (kind_q == cpl_pkg::NONE);
  assign pipe_cyc = (cpl_kind_i != cpl_pkg::NONE) && (kind_q != cpl_pkg::NONE) && !send_i;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      kind_q <= cpl_pkg::NONE;
    else
      kind_q <= cpl_kind_i;
  end

  // extra bytes the Avalon side returns to keep 64-bit alignment
  assign dwlen_gte_4 = |req_dwlen_i[10:2];

  always_comb
  begin
    case (req_dwlen_i[1:0])
      2'd1:
        over_rd_bytes = cpl_pkg::crd_t'(12);
      2'd2:
        over_rd_bytes = (req_dwaddr_i[1:0] == 2'd3) ? cpl_pkg::crd_t'(24) : cpl_pkg::crd_t'(8);
      2'd3:
        over_rd_bytes = req_dwaddr_i[1] ? cpl_pkg::crd_t'(20) : cpl_pkg::crd_t'(4);
      default:
        over_rd_bytes = ((req_dwaddr_i[1:0] != 2'd0) && dwlen_gte_4) ? cpl_pkg::crd_t'(16)
                                                                     : cpl_pkg::crd_t'(0);
    endcase
  end

  // bytes returned so far, counts up only
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      limit_q <= '0;
    else if (TxReadDataValid_i)
      limit_q <= limit_q + cpl_pkg::crd_t'(cpl_pkg::BEAT_BYTES);
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      consumed_q <= '0;
    else if (ld_bcnt_i)
      consumed_q <= consumed_q + over_rd_bytes;
    else if (send_i)
      consumed_q <= consumed_q + cpl_pkg::crd_t'(bytes_sent_i);
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      required_q <= '0;
    else if (wait_cyc)
      required_q <= consumed_q + cpl_pkg::crd_t'(bytes_sent_i);
  end

  // difference wraps, anything in the lower half means enough data is back
  assign avail = limit_q - required_q;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      payload_ok_q <= 1'b0;
    else
      payload_ok_q <= pipe_cyc && (avail <= cpl_pkg::crd_t'(cpl_pkg::CREDIT_WINDOW));
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      buff_addr_q <= '0;
    else if (TxReadDataValid_i)
      buff_addr_q <= buff_addr_q + 1'b1;
  end

  assign payload_ok_o   = payload_ok_q;
  assign CplRamWrAddr_o = buff_addr_q;

endmodule

/* cpl_split_fsm.sv */
`timescale 1ns/10ps

module cpl_split_fsm (
  input  logic               AvlClk_i,
  input  logic               Rstn_i,
  input  logic               RxPndgRdFifoEmpty_i,
  input  logic               CmdFifoBusy_i,
  input  logic [3:0]         CmdFifoUsedw_i,
  input  logic [2:0]         max_payload_code_i,
  input  logic [4:0]         req_dwaddr_i,
  input  logic [10:0]        req_dwlen_i,
  input  logic               payload_ok_i,
  output logic               RxPndgRdFifoRdReq_o,
  output logic               ld_bcnt_o,
  output logic               send_o,
  output logic               first_cpl_o,
  output cpl_pkg::cpl_kind_t cpl_kind_o,
  output cpl_pkg::bcnt_t     bytes_sent_o,
  output cpl_pkg::bcnt_t     curr_bcnt_o,
  output logic               idle_o
);

  cpl_pkg::txresp_state_t state_q;
  cpl_pkg::txresp_state_t state_d;
  logic                   first_q;
  cpl_pkg::bcnt_t         curr_bcnt_q;
  cpl_pkg::bcnt_t         bytes_to_rcb;
  cpl_pkg::bcnt_t         max_payload;
  logic                   fifo_ok;

  // room in the command FIFO and no hold from the transmit side
  assign fifo_ok = ~CmdFifoBusy_i && (CmdFifoUsedw_i < 4'(cpl_pkg::CMD_FIFO_LIMIT));

  // distance from the start address to the next 128 byte boundary
  assign bytes_to_rcb = cpl_pkg::bcnt_t'(cpl_pkg::RCB_BYTES)
                      - cpl_pkg::bcnt_t'({req_dwaddr_i, 2'b00});

  assign max_payload = (max_payload_code_i == 3'b000) ? cpl_pkg::bcnt_t'(cpl_pkg::MPS_SMALL)
                                                      : cpl_pkg::bcnt_t'(cpl_pkg::MPS_LARGE);

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      state_q <= cpl_pkg::IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      cpl_pkg::IDLE:
        if (!RxPndgRdFifoEmpty_i)
          state_d = cpl_pkg::RD_FIFO;
      cpl_pkg::RD_FIFO:
        state_d = cpl_pkg::LD_BCNT;
      cpl_pkg::LD_BCNT:
        state_d = cpl_pkg::WAIT_DATA;
      cpl_pkg::WAIT_DATA:
        if (fifo_ok)
        begin
          // a first completion stops at the boundary, later ones at max payload
          if (first_q)
            state_d = (curr_bcnt_q > bytes_to_rcb) ? cpl_pkg::WAIT_FIRST : cpl_pkg::WAIT_LAST;
          else
            state_d = (curr_bcnt_q > max_payload) ? cpl_pkg::WAIT_MAX : cpl_pkg::WAIT_LAST;
        end
      cpl_pkg::WAIT_FIRST:
        state_d = cpl_pkg::PIPE_FIRST;
      cpl_pkg::WAIT_MAX:
        state_d = cpl_pkg::PIPE_MAX;
      cpl_pkg::WAIT_LAST:
        state_d = cpl_pkg::PIPE_LAST;
      cpl_pkg::PIPE_FIRST:
        if (payload_ok_i && fifo_ok)
          state_d = cpl_pkg::SEND_FIRST;
      cpl_pkg::PIPE_MAX:
        if (payload_ok_i && fifo_ok)
          state_d = cpl_pkg::SEND_MAX;
      cpl_pkg::PIPE_LAST:
        if (payload_ok_i && fifo_ok)
          state_d = cpl_pkg::SEND_LAST;
      cpl_pkg::SEND_FIRST,
      cpl_pkg::SEND_MAX:
        state_d = cpl_pkg::WAIT_DATA;
      cpl_pkg::SEND_LAST:
        state_d = cpl_pkg::DONE;
      default:
        state_d = cpl_pkg::IDLE;
    endcase
  end

  // completion kind for the wait, pipe and send stages
  always_comb
  begin
    case (state_q)
      cpl_pkg::WAIT_FIRST, cpl_pkg::PIPE_FIRST, cpl_pkg::SEND_FIRST:
        cpl_kind_o = cpl_pkg::FIRST;
      cpl_pkg::WAIT_MAX, cpl_pkg::PIPE_MAX, cpl_pkg::SEND_MAX:
        cpl_kind_o = cpl_pkg::MAX;
      cpl_pkg::WAIT_LAST, cpl_pkg::PIPE_LAST, cpl_pkg::SEND_LAST:
        cpl_kind_o = cpl_pkg::LAST;
      default:
        cpl_kind_o = cpl_pkg::NONE;
    endcase
  end

  always_comb
  begin
    case (cpl_kind_o)
      cpl_pkg::FIRST: bytes_sent_o = bytes_to_rcb;
      cpl_pkg::MAX:   bytes_sent_o = max_payload;
      cpl_pkg::LAST:  bytes_sent_o = curr_bcnt_q;
      default:        bytes_sent_o = '0;
    endcase
  end

  // set for a new read, cleared once the boundary completion is out
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      first_q <= 1'b0;
    else if (ld_bcnt_o)
      first_q <= 1'b1;
    else if (state_q == cpl_pkg::SEND_FIRST)
      first_q <= 1'b0;
  end

  // bytes of the read not yet covered by a completion
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      curr_bcnt_q <= '0;
    else if (ld_bcnt_o)
      curr_bcnt_q <= {req_dwlen_i, 2'b00};
    else if (send_o)
      curr_bcnt_q <= curr_bcnt_q - bytes_sent_o;
  end

  assign RxPndgRdFifoRdReq_o = (state_q == cpl_pkg::RD_FIFO);
  assign ld_bcnt_o           = (state_q == cpl_pkg::LD_BCNT);
  assign send_o              = (state_q == cpl_pkg::SEND_FIRST) ||
                               (state_q == cpl_pkg::SEND_MAX) ||
                               (state_q == cpl_pkg::SEND_LAST);
  assign first_cpl_o         = first_q;
  assign curr_bcnt_o         = curr_bcnt_q;
  assign idle_o              = (state_q == cpl_pkg::IDLE);

endmodule

/* cpl_pkg.sv */
package cpl_pkg;

  // widths of the request word, the command word and the counters
  localparam int REQ_W       = 57;
  localparam int CMD_W       = 99;
  localparam int BCNT_W      = 13;
  localparam int REM_W       = 12;
  localparam int CRD_W       = 11;
  localparam int BUFF_ADDR_W = 9;

  // byte quantities of the read data path
  localparam int BEAT_BYTES     = 16;
  localparam int RCB_BYTES      = 128;
  localparam int MPS_SMALL      = 128;
  localparam int MPS_LARGE      = 256;
  localparam int CMD_FIFO_LIMIT = 8;
  localparam int CREDIT_WINDOW  = 1024;

  // max payload code in the device control register
  localparam int MPS_CODE_LO = 5;
  localparam int MPS_CODE_HI = 7;

  // fields of the pending read request
  localparam int TAG_LO    = 0;
  localparam int TAG_HI    = 7;
  localparam int DWADDR_LO = 10;
  localparam int DWADDR_HI = 14;
  localparam int RID_LO    = 16;
  localparam int RID_HI    = 31;
  localparam int DWLEN_LO  = 32;
  localparam int DWLEN_HI  = 42;
  localparam int FBE_LO    = 43;
  localparam int FBE_HI    = 46;
  localparam int ATTR_LO   = 47;
  localparam int ATTR_HI   = 48;
  localparam int TC_LO     = 49;
  localparam int TC_HI     = 51;
  localparam int LBE_LO    = 52;
  localparam int LBE_HI    = 55;

  // fields of the completion command word, lsb positions
  localparam int CMD_LADDR_LO  = 0;
  localparam int CMD_TAG_LO    = 7;
  localparam int CMD_RID_LO    = 15;
  localparam int CMD_UNS_BIT   = 31;
  localparam int CMD_ONE_BIT   = 68;
  localparam int CMD_FLUSH_BIT = 69;
  localparam int CMD_REM_LO    = 70;
  localparam int CMD_TC_LO     = 82;
  localparam int CMD_DWLEN_LO  = 85;
  localparam int CMD_ATTR_LO   = 94;

  typedef logic [BCNT_W-1:0] bcnt_t;
  typedef logic [CRD_W-1:0]  crd_t;

  // one-hot state encoding of the completion splitter
  typedef enum logic [13:0] {
    IDLE       = 14'h0001,
    RD_FIFO    = 14'h0002,
    LD_BCNT    = 14'h0004,
    WAIT_DATA  = 14'h0008,
    WAIT_FIRST = 14'h0010,
    PIPE_FIRST = 14'h0020,
    SEND_FIRST = 14'h0040,
    WAIT_MAX   = 14'h0080,
    PIPE_MAX   = 14'h0100,
    SEND_MAX   = 14'h0200,
    WAIT_LAST  = 14'h0400,
    PIPE_LAST  = 14'h0800,
    SEND_LAST  = 14'h1000,
    DONE       = 14'h2000
  } txresp_state_t;

  // which completion of a read is in flight
  typedef enum logic [1:0] {
    NONE  = 2'd0,
    FIRST = 2'd1,
    MAX   = 2'd2,
    LAST  = 2'd3
  } cpl_kind_t;

endpackage
